/* flist.f */
logic/core_pkg.sv
logic/ib_if.sv
logic/fetch_unit.sv
logic/instruction_buffer.sv
logic/register_file.sv
logic/execute_unit.sv
logic/tiny_core.sv
test/core_chk.sv
test/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# build the tiny_core testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
    -f flist.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* test/tb_core.sv */
// directed testbench for tiny_core with a Wishbone instruction memory model
// each test loads a program, resets the core and checks every retire against a reference model
// the memory can insert 0 to 3 wait states from a Fibonacci LFSR
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    logic                      clk;
    logic                      rst_n = 1'b0;
    logic                      halt = 1'b0;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic [core_pkg::xlen-1:0] wb_adr;
    logic [core_pkg::xlen-1:0] wb_dat_r = '0;
    logic                      wb_ack = 1'b0;
    logic                      retire_valid;
    logic [core_pkg::xlen-1:0] retire_pc;
    logic [4:0]                retire_rd;
    logic [core_pkg::xlen-1:0] retire_data;
    logic                      illegal_instruction;

    logic [31:0] imem [256];              // word indexed instruction memory
    logic [31:0] prog [$];                // program of the running test
    logic [31:0] ref_regs [32];           // reference register state
    logic [15:0] lfsr = 16'd20181;
    logic        rand_waits = 1'b0;       // wait states on or off
    int          wait_left = -1;          // negative while no bus cycle is being served
    logic [31:0] exp_adr = '0;            // next address the fetch unit should read
    int          ack_count = 0;           // words fetched since reset
    int          errors = 0;
    int          tests_run = 0;

    tiny_core u_dut (.*);
    bind tiny_core core_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int draw_wait();
        int w;
        w = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);
            w = (w << 1) | int'(lfsr[0]);
        end
        return w;
    endfunction

    // memory slave, acks for one cycle after the chosen number of wait states
    always @(posedge clk) begin : mem_model
        int n;
        if (!rst_n || wb_ack) begin
            wb_ack    <= 1'b0;
            wait_left <= -1;
        end else if (wb_cyc && wb_stb) begin
            n = wait_left;
            if (n < 0) n = rand_waits ? draw_wait() : 0;   // a new cycle picks its waits
            if (n == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= imem[wb_adr[9:2]];
            end
            wait_left <= n - 1;
        end
    end

    // every completed read must hit the next word in sequence
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_adr   <= core_pkg::reset_pc;
            ack_count <= 0;
        end else if (wb_cyc && wb_stb && wb_ack) begin
            if (wb_adr !== exp_adr) report_mismatch("wb_adr", exp_adr, wb_adr);
            exp_adr   <= exp_adr + 32'd4;
            ack_count <= ack_count + 1;
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("Error at %0t: %s expected %h got %h", $time, sig, exp_v, got_v);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        core_pkg::instr_t t;
        t.r_type.funct7 = f7;
        t.r_type.rs2    = 5'(rs2);
        t.r_type.rs1    = 5'(rs1);
        t.r_type.funct3 = f3;
        t.r_type.rd     = 5'(rd);
        t.r_type.opcode = core_pkg::op_reg;
        return t;
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                          input int imm);
        core_pkg::instr_t t;
        t.i_type.imm    = 12'(imm);       // shift amounts sit in the low 5 bits
        t.i_type.rs1    = 5'(rs1);
        t.i_type.funct3 = f3;
        t.i_type.rd     = 5'(rd);
        t.i_type.opcode = core_pkg::op_imm;
        return t;
    endfunction

    // expected rd, data and legality of one word, then the register update
    task automatic ref_exec(input logic [31:0] w, output logic [4:0] rd,
                            output logic [31:0] data, output logic ill);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic        alt;
        opc  = w[6:0];
        f3   = w[14:12];
        f7   = w[31:25];
        a    = ref_regs[w[19:15]];
        b    = (opc == core_pkg::op_reg) ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        alt  = (opc == core_pkg::op_reg) && (f7 == core_pkg::f7_alt);
        ill  = 1'b0;
        data = '0;
        if (opc == core_pkg::op_lui) begin
            data = {w[31:12], 12'h000};
        end else if (opc == core_pkg::op_reg || opc == core_pkg::op_imm) begin
            case (f3)
                core_pkg::f3_add: data = alt ? a - b : a + b;
                core_pkg::f3_sll: data = a << b[4:0];
                core_pkg::f3_slt: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                core_pkg::f3_xor: data = a ^ b;
                core_pkg::f3_srl: data = a >> b[4:0];
                core_pkg::f3_or:  data = a | b;
                core_pkg::f3_and: data = a & b;
                default:          ill = 1'b1;      // SLTU and SLTIU are not in the set
            endcase
            if (opc == core_pkg::op_reg && f7 != 7'd0 &&
                !(alt && f3 == core_pkg::f3_add)) ill = 1'b1;
            if (opc == core_pkg::op_imm && f7 != 7'd0 &&
                (f3 == core_pkg::f3_sll || f3 == core_pkg::f3_srl)) ill = 1'b1;
        end else begin
            ill = 1'b1;
        end
        rd = ill ? 5'd0 : w[11:7];
        if (!ill && rd != 5'd0) ref_regs[rd] = data;
    endtask

    // holds reset for 5 cycles and loads the program behind an address-dependent fill
    task automatic apply_reset(input logic rand_on);
        @(posedge clk);
        rst_n      <= 1'b0;
        halt       <= 1'b0;
        rand_waits <= rand_on;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : enc_i(core_pkg::f3_add, 0, 0, i);
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (wb_cyc !== 1'b0) report_mismatch("wb_cyc", 32'd0, 32'(wb_cyc));
        if (wb_stb !== 1'b0) report_mismatch("wb_stb", 32'd0, 32'(wb_stb));
        if (retire_valid !== 1'b0) report_mismatch("retire_valid", 32'd0, 32'(retire_valid));
        if (illegal_instruction !== 1'b0) report_mismatch("illegal_instruction", 32'd0,
                                                          32'(illegal_instruction));
    endtask

    task automatic run_program(input string name, input logic rand_on, input int halt_at,
                               input int halt_len);
        logic [31:0] exp_pc [64];
        logic [4:0]  exp_rd [64];
        logic [31:0] exp_data [64];
        logic        exp_ill [64];
        int          n;
        int          k;
        int          cycles;
        int          halt_left;
        int          halt_seen;
        int          err_start;
        logic        halt_done;
        err_start = errors;
        n = prog.size();
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        for (int i = 0; i < n; i++) begin
            exp_pc[i] = core_pkg::reset_pc + 32'(4 * i);
            ref_exec(prog[i], exp_rd[i], exp_data[i], exp_ill[i]);
        end
        apply_reset(rand_on);
        k = 0;
        cycles = 0;
        halt_left = 0;
        halt_seen = 0;
        halt_done = 1'b0;
        while (k < n && cycles < 20 * n + halt_len + 50) begin
            @(posedge clk);
            cycles++;
            halt_seen = halt ? halt_seen + 1 : 0;   // edges in a row that saw halt
            if (!halt_done && halt_len > 0 && k == halt_at) begin
                halt      <= 1'b1;
                halt_left = halt_len;
                halt_done = 1'b1;
            end else if (halt_left > 0) begin
                halt_left--;
                if (halt_left == 0) begin
                    if (ack_count - k > core_pkg::ib_depth + 1)
                        note_failure($sformatf("%0d words fetched past issue", ack_count - k));
                    halt <= 1'b0;
                end
            end
            @(negedge clk);
            if (cycles == 1 && wb_stb !== 1'b1) report_mismatch("wb_stb", 32'd1, 32'(wb_stb));
            if (retire_valid && halt_seen > 0) begin
                note_failure("instruction retired while halt was high");
            end else if (retire_valid) begin
                if (retire_pc !== exp_pc[k]) report_mismatch("retire_pc", exp_pc[k], retire_pc);
                if (retire_rd !== exp_rd[k])
                    report_mismatch("retire_rd", 32'(exp_rd[k]), 32'(retire_rd));
                if (illegal_instruction !== exp_ill[k])
                    report_mismatch("illegal_instruction", 32'(exp_ill[k]),
                                    32'(illegal_instruction));
                if (!exp_ill[k] && retire_data !== exp_data[k])
                    report_mismatch("retire_data", exp_data[k], retire_data);
                k++;
            end
        end
        if (k < n) begin
            $display("Failure at %0t: test %s timed out after %0d of %0d retires",
                     $time, name, k, n);
            $display("Regression failed");
            $finish;
        end else begin
            tests_run++;
            $display("test %s: %0d retires checked, %0d errors", name, k, errors - err_start);
        end
    endtask

    // immediate ops, LUI and writes to x0
    task automatic test_imm_ops();
        prog = {};
        prog.push_back(enc_i(core_pkg::f3_add, 1, 0, 5));
        prog.push_back(enc_i(core_pkg::f3_add, 2, 0, -7));
        prog.push_back(enc_i(core_pkg::f3_slt, 3, 2, -3));
        prog.push_back(enc_i(core_pkg::f3_xor, 4, 1, 'h0f0));
        prog.push_back(enc_i(core_pkg::f3_or,  5, 2, 'h100));
        prog.push_back(enc_i(core_pkg::f3_and, 6, 2, 'h07f));
        prog.push_back(enc_i(core_pkg::f3_sll, 7, 1, 4));
        prog.push_back(enc_i(core_pkg::f3_srl, 8, 2, 3));
        prog.push_back({20'habcde, 5'd9, core_pkg::op_lui});
        prog.push_back(enc_i(core_pkg::f3_add, 0, 1, 9));        // x0 keeps zero
        prog.push_back(enc_i(core_pkg::f3_add, 10, 0, 1));
        prog.push_back(enc_i(core_pkg::f3_add, 11, 9, 'h7ff));
        run_program("imm_ops", 1'b0, 0, 0);
    endtask

    // dependent register ops that need the bypass on every step
    task automatic load_reg_program();
        prog = {};
        prog.push_back(enc_i(core_pkg::f3_add, 1, 0, -20));
        prog.push_back(enc_i(core_pkg::f3_add, 2, 0, 3));
        prog.push_back(enc_r(core_pkg::f7_alt, core_pkg::f3_add, 3, 1, 2));
        prog.push_back(enc_r(7'd0, core_pkg::f3_slt, 4, 3, 1));
        prog.push_back(enc_r(7'd0, core_pkg::f3_slt, 5, 1, 3));
        prog.push_back(enc_r(7'd0, core_pkg::f3_sll, 6, 3, 2));
        prog.push_back(enc_r(7'd0, core_pkg::f3_srl, 7, 6, 2));
        prog.push_back(enc_r(7'd0, core_pkg::f3_xor, 8, 7, 1));
        prog.push_back(enc_r(7'd0, core_pkg::f3_or,  9, 8, 4));
        prog.push_back(enc_r(7'd0, core_pkg::f3_and, 10, 9, 1));
        prog.push_back(enc_r(7'd0, core_pkg::f3_add, 11, 10, 10));
        prog.push_back(enc_r(core_pkg::f7_alt, core_pkg::f3_add, 12, 0, 11));
        prog.push_back(enc_r(7'd0, core_pkg::f3_slt, 13, 2, 12));
    endtask

    task automatic test_reg_ops();
        load_reg_program();
        run_program("reg_ops", 1'b0, 0, 0);
    endtask

    task automatic test_rand_waits();
        load_reg_program();
        run_program("rand_waits", 1'b1, 0, 0);
    endtask

    // a rotating chain over x1..x6, halted long enough to fill the buffer
    task automatic test_halt();
        prog = {};
        for (int i = 0; i < 20; i++) begin
            prog.push_back(enc_i(core_pkg::f3_add, i % 6 + 1, (i + 5) % 6 + 1, i + 1));
        end
        run_program("halt", 1'b0, 4, 16);
    endtask

    task automatic test_illegal();
        prog = {};
        prog.push_back(enc_i(core_pkg::f3_add, 1, 0, 7));
        prog.push_back(32'h0000_2083);                           // LW x1, 0(x0)
        prog.push_back(enc_i(core_pkg::f3_add, 2, 1, 1));
        prog.push_back(enc_r(7'd0, 3'b011, 3, 1, 2));            // SLTU
        prog.push_back(enc_r(7'd0, core_pkg::f3_add, 4, 3, 1));
        prog.push_back(enc_r(7'b0000001, core_pkg::f3_add, 5, 1, 2));   // MUL
        prog.push_back(enc_r(core_pkg::f7_alt, core_pkg::f3_add, 6, 2, 1));
        run_program("illegal", 1'b1, 0, 0);
    endtask

    initial begin
        test_imm_ops();
        test_reg_ops();
        test_rand_waits();
        test_halt();
        test_illegal();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/core_chk.sv */
// concurrent checks on the Wishbone fetch bus and the retire port of tiny_core
// bound into tiny_core from the testbench, it only watches and drives nothing
`timescale 1ns/1ps
`default_nettype none

module core_chk (
    input wire logic                      clk,
    input wire logic                      rst_n,
    input wire logic                      halt,
    input wire logic                      wb_cyc,
    input wire logic                      wb_stb,
    input wire logic [core_pkg::xlen-1:0] wb_adr,
    input wire logic                      wb_ack,
    input wire logic                      retire_valid,
    input wire logic                      illegal_instruction
);

    // a strobe without ack stays up with the same address into the next cycle
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("wb_adr moved or wb_stb dropped before wb_ack");

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // halt seen on the previous edge means nothing was accepted there
    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (halt && $past(halt)) |-> !retire_valid)
        else $error("retire while halt held");

    a_illegal_retires: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_instruction |-> retire_valid)
        else $error("illegal_instruction without retire_valid");

endmodule

`default_nettype wire

/* logic/tiny_core.sv */
// top level of the small in-order rv32i core
// fetch reads instruction memory over Wishbone and feeds the buffer, which feeds execute
// the retire port reports every completed instruction and halt holds back issue
`timescale 1ns/1ps
`default_nettype none

module tiny_core (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      halt,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [core_pkg::xlen-1:0]      wb_adr,
    input  wire logic [core_pkg::xlen-1:0] wb_dat_r,
    input  wire logic                      wb_ack,
    output logic                           retire_valid,
    output logic [core_pkg::xlen-1:0]      retire_pc,
    output logic [core_pkg::reg_aw-1:0]    retire_rd,
    output logic [core_pkg::xlen-1:0]      retire_data,
    output logic                           illegal_instruction
);

    ib_if fetch_ib ();   // fetch to buffer
    ib_if issue_ib ();   // buffer to execute

    logic                        space_free;
    logic [core_pkg::reg_aw-1:0] rs1_addr;
    logic [core_pkg::reg_aw-1:0] rs2_addr;
    logic [core_pkg::xlen-1:0]   rs1_data;
    logic [core_pkg::xlen-1:0]   rs2_data;
    logic                        rf_we;
    logic [core_pkg::reg_aw-1:0] rf_rd;
    logic [core_pkg::xlen-1:0]   rf_data;

    // front end
    fetch_unit u_fetch (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_adr, .wb_dat_r, .wb_ack, .space_free,
        .ib (fetch_ib.writer)
    );

    instruction_buffer u_ib (
        .clk, .rst_n, .space_free,
        .in_side  (fetch_ib.reader),
        .out_side (issue_ib.writer)
    );

    // execute and writeback
    register_file u_rf (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .we (rf_we), .rd_addr (rf_rd), .rd_data (rf_data)
    );

    execute_unit u_exec (
        .clk, .rst_n, .halt,
        .ib (issue_ib.reader),
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .rf_we, .rf_rd, .rf_data,
        .retire_valid, .retire_pc, .retire_rd, .retire_data, .illegal_instruction
    );

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
// single-stage decode and execute for the supported rv32i integer subset
// takes one packet per cycle unless halted and registers the result one cycle later
// the result register drives both the retire report and the register file write
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        halt,
    ib_if.reader                             ib,
    output logic [core_pkg::reg_aw-1:0]      rs1_addr,
    output logic [core_pkg::reg_aw-1:0]      rs2_addr,
    input  wire logic [core_pkg::xlen-1:0]   rs1_data,
    input  wire logic [core_pkg::xlen-1:0]   rs2_data,
    output logic                             rf_we,
    output logic [core_pkg::reg_aw-1:0]      rf_rd,
    output logic [core_pkg::xlen-1:0]        rf_data,
    output logic                             retire_valid,
    output logic [core_pkg::xlen-1:0]        retire_pc,
    output logic [core_pkg::reg_aw-1:0]      retire_rd,
    output logic [core_pkg::xlen-1:0]        retire_data,
    output logic                             illegal_instruction
);

    core_pkg::instr_t          w;
    logic                      accept;
    logic                      is_reg;
    logic                      is_imm;
    logic                      is_lui;
    logic                      f3_known;     // funct3 is one of the seven supported codes
    logic                      is_shift;
    logic                      legal;
    logic                      alu_sub;
    logic [core_pkg::xlen-1:0] imm_i;
    logic [core_pkg::xlen-1:0] lui_val;
    logic [core_pkg::xlen-1:0] src1;
    logic [core_pkg::xlen-1:0] src2;
    logic [core_pkg::xlen-1:0] op_b;
    logic [core_pkg::xlen-1:0] alu_out;
    logic [core_pkg::xlen-1:0] result;

    // result register
    logic                        res_valid;
    logic                        res_illegal;
    logic [core_pkg::xlen-1:0]   res_pc;
    logic [core_pkg::reg_aw-1:0] res_rd;
    logic [core_pkg::xlen-1:0]   res_data;

    assign ib.ready = !halt;              // halt is the only thing that stalls issue
    assign accept   = ib.valid && !halt;
    assign w        = ib.instr;

    assign is_reg = (w.r_type.opcode == core_pkg::op_reg);
    assign is_imm = (w.r_type.opcode == core_pkg::op_imm);
    assign is_lui = (w.r_type.opcode == core_pkg::op_lui);

    assign is_shift = (w.i_type.funct3 == core_pkg::f3_sll) ||
                      (w.i_type.funct3 == core_pkg::f3_srl);
    assign f3_known = (w.i_type.funct3 != 3'b011);   // only SLTU is missing from the set
    assign alu_sub  = is_reg && (w.r_type.funct7 == core_pkg::f7_alt);

    // for shift immediates the top seven immediate bits sit in the funct7 field
    always_comb begin
        legal = is_lui;
        if (is_reg) begin
            legal = f3_known && ((w.r_type.funct7 == '0) ||
                    (alu_sub && (w.r_type.funct3 == core_pkg::f3_add)));
        end else if (is_imm) begin
            legal = f3_known && (!is_shift || (w.r_type.funct7 == '0));
        end
    end

    assign imm_i   = {{(core_pkg::xlen - 12){w.i_type.imm[11]}}, w.i_type.imm};
    assign lui_val = {w.i_type.imm, w.i_type.rs1, w.i_type.funct3, 12'b0};

    assign rs1_addr = w.r_type.rs1;
    assign rs2_addr = w.r_type.rs2;   // harmless read for immediate forms

    // forward the pending result when it targets a source, x0 never matches
    assign src1 = (res_valid && (res_rd != '0) && (res_rd == rs1_addr)) ? res_data : rs1_data;
    assign src2 = (res_valid && (res_rd != '0) && (res_rd == rs2_addr)) ? res_data : rs2_data;
    assign op_b = is_reg ? src2 : imm_i;

    always_comb begin
        case (w.i_type.funct3)
            core_pkg::f3_add: alu_out = alu_sub ? (src1 - op_b) : (src1 + op_b);
            core_pkg::f3_sll: alu_out = src1 << op_b[4:0];
            core_pkg::f3_slt: alu_out = {{(core_pkg::xlen - 1){1'b0}},
                                         ($signed(src1) < $signed(op_b))};
            core_pkg::f3_xor: alu_out = src1 ^ op_b;
            core_pkg::f3_srl: alu_out = src1 >> op_b[4:0];   // logical shift only
            core_pkg::f3_or:  alu_out = src1 | op_b;
            core_pkg::f3_and: alu_out = src1 & op_b;
            default:          alu_out = '0;
        endcase
    end

    assign result = is_lui ? lui_val : alu_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid   <= 1'b0;
            res_illegal <= 1'b0;
        end else begin
            res_valid   <= accept;           // one retire per accepted packet
            res_illegal <= accept && !legal;
        end
    end

    // an illegal word reports rd as zero so it neither writes nor forwards
    always_ff @(posedge clk) begin
        if (accept) begin
            res_pc   <= ib.pc;
            res_rd   <= legal ? w.i_type.rd : '0;
            res_data <= legal ? result : '0;
        end
    end

    assign rf_we   = res_valid && !res_illegal;
    assign rf_rd   = res_rd;
    assign rf_data = res_data;

    assign retire_valid        = res_valid;
    assign retire_pc           = res_pc;
    assign retire_rd           = res_rd;
    assign retire_data         = res_data;
    assign illegal_instruction = res_illegal;

endmodule

`default_nettype wire

/* logic/register_file.sv */
// integer register file with two asynchronous read ports and one write port
// x0 is not stored and always reads as zero
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [core_pkg::reg_aw-1:0] rs1_addr,
    input  wire logic [core_pkg::reg_aw-1:0] rs2_addr,
    output logic [core_pkg::xlen-1:0]        rs1_data,
    output logic [core_pkg::xlen-1:0]        rs2_data,
    input  wire logic                        we,
    input  wire logic [core_pkg::reg_aw-1:0] rd_addr,
    input  wire logic [core_pkg::xlen-1:0]   rd_data
);

    // x1 up to x31 only
    logic [core_pkg::xlen-1:0] regs [1:(2**core_pkg::reg_aw)-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**core_pkg::reg_aw; i++) begin
                regs[i] <= '0;             // every register starts at zero
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;      // a write aimed at x0 is dropped
        end
    end

    // reads see the value from before a write on the same edge
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* logic/instruction_buffer.sv */
// circular FIFO of fetched instruction packets between fetch and execute
// both sides use the valid/ready handshake of ib_if
// space_free tells the fetch unit it may start a read without overrunning the buffer
`timescale 1ns/1ps
`default_nettype none

module instruction_buffer (
    input  wire logic clk,
    input  wire logic rst_n,
    ib_if.reader      in_side,       // from the fetch unit
    ib_if.writer      out_side,      // to the execute unit
    output logic      space_free
);

    logic [core_pkg::xlen-1:0]     pc_mem    [core_pkg::ib_depth];
    core_pkg::instr_t              instr_mem [core_pkg::ib_depth];
    logic [core_pkg::ib_ptr_w-1:0] wr_ptr;
    logic [core_pkg::ib_ptr_w-1:0] rd_ptr;
    logic [core_pkg::ib_ptr_w:0]   count;       // packets currently held
    logic [core_pkg::ib_ptr_w:0]   free_slots;
    logic                          push;
    logic                          pop;

    assign push = in_side.valid && in_side.ready;
    assign pop  = out_side.valid && out_side.ready;

    assign in_side.ready = (count != core_pkg::ib_full);   // low only when every slot is taken
    assign free_slots    = core_pkg::ib_full - count;
    assign space_free    = (free_slots >= 2);   // one slot may already be claimed by fetch

    // the oldest packet is always presented at the output
    assign out_side.valid = (count != '0);
    assign out_side.pc    = pc_mem[rd_ptr];
    assign out_side.instr = instr_mem[rd_ptr];

    // storage needs no reset because count says which slots are live
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= in_side.pc;
            instr_mem[wr_ptr] <= in_side.instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == core_pkg::ib_last) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == core_pkg::ib_last) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle, or one in and one out
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
// instruction fetch master on a read-only Wishbone classic bus
// runs one read at a time and hands each word with its pc to the instruction buffer
// a read only starts when the buffer has room for it beyond any packet still waiting here
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [core_pkg::xlen-1:0]      wb_adr,
    input  wire logic [core_pkg::xlen-1:0] wb_dat_r,
    input  wire logic                      wb_ack,
    input  wire logic                      space_free,   // buffer has two or more free slots
    ib_if.writer                           ib
);

    logic                      busy;        // a bus cycle is open
    logic                      start;       // open a new bus cycle on this edge
    logic                      done;        // the open bus cycle ends on this edge
    logic [core_pkg::xlen-1:0] fetch_pc;    // address of the word being read or read next

    // one-entry output register toward the buffer
    logic                      pkt_valid;
    logic [core_pkg::xlen-1:0] pkt_pc;
    core_pkg::instr_t          pkt_instr;

    // two free slots leave room for the word in flight and for a packet still held here
    assign start = !busy && space_free;
    assign done  = busy && wb_ack;     // an ack outside a cycle is ignored

    // cyc and stb are the same flop since this master never holds the bus idle
    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_adr = fetch_pc;          // stable for the whole cycle because it only moves on done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            fetch_pc <= core_pkg::reset_pc;
        end else if (start) begin
            busy <= 1'b1;              // stb rises in the next cycle
        end else if (done) begin
            busy     <= 1'b0;          // drop cyc and stb right after the ack
            fetch_pc <= fetch_pc + core_pkg::pc_step;
        end
    end

    // the packet is valid toward the buffer in the cycle after the ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
        end else if (done) begin
            pkt_valid <= 1'b1;
        end else if (ib.ready) begin
            pkt_valid <= 1'b0;         // taken by the buffer on this edge
        end
    end

    // payload only loads on an ack, so it stays put while valid waits for ready
    always_ff @(posedge clk) begin
        if (done) begin
            pkt_pc    <= fetch_pc;
            pkt_instr <= core_pkg::instr_t'(wb_dat_r);
        end
    end

    assign ib.valid = pkt_valid;
    assign ib.pc    = pkt_pc;
    assign ib.instr = pkt_instr;

endmodule

`default_nettype wire

/* logic/ib_if.sv */
// instruction packet link between fetch, the instruction buffer and execute
// the writer holds pc and instr stable from the rise of valid until ready is seen
// a packet moves on each rising edge with valid and ready both high
`timescale 1ns/1ps
`default_nettype none

interface ib_if;

    logic [core_pkg::xlen-1:0] pc;      // address the word was fetched from
    core_pkg::instr_t          instr;   // the raw instruction word
    logic                      valid;   // writer has a packet on the link
    logic                      ready;   // reader takes the packet on this edge

    // producer side of the link
    modport writer (
        output pc,
        output instr,
        output valid,
        input  ready
    );

    // consumer side of the link
    modport reader (
        input  pc,
        input  instr,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

/* logic/core_pkg.sv */
// shared constants and the instruction word layout for the small rv32i core
// every block refers to these by scoped name and none of them imports the package
// the testbench also builds its programs from the opcode and funct codes here
`default_nettype none

package core_pkg;

    localparam int xlen   = 32;       // data and address width
    localparam int reg_aw = 5;        // register index width, 32 architectural registers

    localparam logic [xlen-1:0] reset_pc = '0;    // address of the first fetch
    localparam logic [xlen-1:0] pc_step  = 4;     // every instruction word is four bytes

    // instruction buffer geometry
    localparam int ib_depth = 4;
    localparam int ib_ptr_w = $clog2(ib_depth);
    localparam logic [ib_ptr_w-1:0] ib_last = ib_ptr_w'(ib_depth - 1);    // last slot index
    localparam logic [ib_ptr_w:0]   ib_full = (ib_ptr_w + 1)'(ib_depth);  // occupancy when full

    // major opcodes that the execute unit understands
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;

    // funct3 codes are shared by the register and the immediate forms
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    localparam logic [6:0] f7_alt = 7'b0100000;   // turns ADD into SUB

    // one 32-bit word seen either as an R-type or as an I-type instruction
    // the top 20 bits hold the LUI immediate in both views
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [reg_aw-1:0] rs2;
            logic [reg_aw-1:0] rs1;
            logic [2:0]        funct3;
            logic [reg_aw-1:0] rd;
            logic [6:0]        opcode;
        } r_type;
        struct packed {
            logic [11:0]       imm;
            logic [reg_aw-1:0] rs1;
            logic [2:0]        funct3;
            logic [reg_aw-1:0] rd;
            logic [6:0]        opcode;
        } i_type;
    } instr_t;

endpackage

`default_nettype wire
